//--- src.f
source/ringPkg.sv
source/packetQueue.sv
source/creditCounter.sv
source/sharedRam.sv
source/ringBridgeCtrl.sv
source/ringRamNode.sv
sim/ringRamNodeTb.sv

//--- sim/ringRamNodeTb.sv
// Testbench for the ring memory node.
// Plays the upstream hop from a table of requests and the downstream hop
// that returns credits after a random delay. Every packet leaving the node
// is compared in order with the expected packet from the same table.

`timescale 1ns/1ps

module ringRamNodeTb import ringPkg::*; ();

  localparam int MAX_DELAY   = 6;
  localparam int HOLD_CYCLES = 30;
  localparam int MARGIN      = 40;

  logic       CLK;
  logic       rstN;
  ringPacketT ringIn;
  logic       ringInValid;
  logic       ringInCredit;
  ringPacketT ringOut;
  logic       ringOutValid;
  logic       ringOutCredit;

  // Stimulus table, one entry per packet
  string      names[$];
  ringPacketT inPkts[$];
  ringPacketT expPkts[$];
  bit         holdFlags[$];

  int errors       = 0;
  int inIdx        = 0;
  int outIdx       = 0;
  int upCredits    = IN_QUEUE_DEPTH;
  int creditPulses = 0;
  int cycle        = 0;
  int holdUntil    = 0;
  int holdSends    = 0;
  int creditDue[$];
  int delays[$];
  bit started      = 1'b0;

  ringRamNode i_ringRamNode (
    .CLK           (CLK),
    .rstN          (rstN),
    .ringIn        (ringIn),
    .ringInValid   (ringInValid),
    .ringInCredit  (ringInCredit),
    .ringOut       (ringOut),
    .ringOutValid  (ringOutValid),
    .ringOutCredit (ringOutCredit)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic checkPacket(input string name, input ringPacketT exp, input ringPacketT act);
    if (exp !== act) begin
      $display("Error %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Error %s: expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error %s: expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  // The expected packet keeps srcId, addr and mask of the request
  task automatic addEntry(input string name, input kindT kind, input nodeIdT src,
                          input addrT addr, input byteMaskT mask, input wordT data,
                          input kindT expKind, input wordT expData, input bit hold);
    ringPacketT inPkt;
    ringPacketT expPkt;
    inPkt.kind   = kind;
    inPkt.srcId  = src;
    inPkt.addr   = addr;
    inPkt.mask   = mask;
    inPkt.data   = data;
    expPkt       = inPkt;
    expPkt.kind  = expKind;
    expPkt.data  = expData;
    names.push_back(name);
    inPkts.push_back(inPkt);
    expPkts.push_back(expPkt);
    holdFlags.push_back(hold);
    // Delay before the downstream hop returns the credit of this packet
    delays.push_back($urandom % (MAX_DELAY + 1));
  endtask

  // Upstream hop sends one packet per clock while it holds a credit
  always @(posedge CLK) begin
    if (!rstN || !started) begin
      ringInValid <= 1'b0;
    end else begin
      if (ringInCredit === 1'b1) begin
        upCredits++;
        creditPulses++;
      end
      if (inIdx < inPkts.size() && upCredits > 0) begin
        ringIn      <= inPkts[inIdx];
        ringInValid <= 1'b1;
        inIdx++;
        upCredits--;
      end else begin
        ringInValid <= 1'b0;
      end
    end
  end

  // Downstream hop checks each packet and hands its credit back later
  always @(posedge CLK) begin
    cycle++;
    if (!rstN) begin
      ringOutCredit <= 1'b0;
    end else begin
      if (ringOutValid === 1'b1) begin
        if (outIdx < expPkts.size()) begin
          checkPacket(names[outIdx], expPkts[outIdx], ringOut);
          if (holdFlags[outIdx]) begin
            holdUntil = cycle + HOLD_CYCLES;
          end
          if (cycle < holdUntil) begin
            holdSends++;
          end
          creditDue.push_back(cycle + delays[outIdx]);
        end else begin
          $display("Packet left the node after all expected packets had arrived");
          errors++;
          creditDue.push_back(cycle);
        end
        outIdx++;
      end
      // Credits stay with the downstream hop during a withhold stretch
      if (creditDue.size() > 0 && creditDue[0] <= cycle && cycle >= holdUntil) begin
        ringOutCredit <= 1'b1;
        void'(creditDue.pop_front());
      end else begin
        ringOutCredit <= 1'b0;
      end
    end
  end

  initial begin
    void'($urandom(32'h6cf5));
    rstN          = 1'b0;
    ringIn        = '0;
    ringInValid   = 1'b0;
    ringOutCredit = 1'b0;

    // Word 4 gets a full write, then its top byte alone
    addEntry("write full A", KIND_WRITE, 4'd1, 32'h0001_0010, 4'hF, 32'hDEAD_BEEF,
             KIND_RESP, 32'h0, 1'b0);
    addEntry("read A", KIND_READ, 4'd2, 32'h0001_0010, 4'hF, 32'h0,
             KIND_RESP, 32'hDEAD_BEEF, 1'b0);
    addEntry("miss read", KIND_READ, 4'd3, 32'h0002_0010, 4'hF, 32'h1234_5678,
             KIND_READ, 32'h1234_5678, 1'b0);
    addEntry("write full B", KIND_WRITE, 4'd4, 32'h0001_0AB0, 4'hF, 32'h1122_3344,
             KIND_RESP, 32'h0, 1'b0);
    addEntry("pass resp", KIND_RESP, 4'd5, 32'h0001_0020, 4'hF, 32'hCAFE_F00D,
             KIND_RESP, 32'hCAFE_F00D, 1'b1);
    // Lanes 0 and 2 take the new bytes
    addEntry("write partial B", KIND_WRITE, 4'd6, 32'h0001_0AB0, 4'b0101, 32'hAABB_CCDD,
             KIND_RESP, 32'h0, 1'b0);
    addEntry("read B", KIND_READ, 4'd7, 32'h0001_0AB0, 4'hF, 32'h0,
             KIND_RESP, 32'h11BB_33DD, 1'b0);
    // Same word index as B but outside the window, so B must not change
    addEntry("miss write", KIND_WRITE, 4'd8, 32'h0003_0AB0, 4'hF, 32'h55AA_55AA,
             KIND_WRITE, 32'h55AA_55AA, 1'b0);
    addEntry("read B again", KIND_READ, 4'd9, 32'h0001_0AB0, 4'b0011, 32'h0,
             KIND_RESP, 32'h11BB_33DD, 1'b0);
    addEntry("write partial A", KIND_WRITE, 4'd10, 32'h0001_0010, 4'b1000, 32'h7700_0000,
             KIND_RESP, 32'h0, 1'b0);
    addEntry("read A unaligned", KIND_READ, 4'd11, 32'h0001_0013, 4'hF, 32'h0,
             KIND_RESP, 32'h77AD_BEEF, 1'b0);
    addEntry("pass kind zero", 2'd0, 4'd12, 32'h0001_0010, 4'hF, 32'h0BAD_C0DE,
             2'd0, 32'h0BAD_C0DE, 1'b0);

    repeat (5) @(posedge CLK);
    rstN <= 1'b1;

    // Nothing may leave the node before the first packet arrives
    repeat (3) begin
      @(negedge CLK);
      checkFlag("idle ringOutValid", 1'b0, ringOutValid);
      checkFlag("idle ringInCredit", 1'b0, ringInCredit);
    end
    started = 1'b1;

    wait (outIdx == expPkts.size());
    // The last queue credit pulses before its packet leaves
    repeat (4) @(negedge CLK);
    checkFlag("final ringOutValid", 1'b0, ringOutValid);
    checkCount("packets out", expPkts.size(), outIdx);
    checkCount("credit pulses", inPkts.size(), creditPulses);
    checkCount("upstream credits", IN_QUEUE_DEPTH, upCredits);
    if (holdSends > OUT_CREDITS) begin
      $display("%0d packets left while credits were withheld, limit is %0d",
               holdSends, OUT_CREDITS);
      errors++;
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Allows every packet its pipeline time and worst credit delay
  initial begin
    int limit;
    // The table is complete once the first edge arrives
    @(posedge CLK);
    limit = 5 + 3 + expPkts.size() * (3 + MAX_DELAY) + HOLD_CYCLES + MARGIN;
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, outputs stopped arriving (%0d of %0d)",
             limit, outIdx, expPkts.size());
    $display("Run finished with %0d errors", errors + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- source/ringRamNode.sv
// Top level of the ring memory node.
// Connects the ring input to the queue, the queue to the controller, the
// controller to the RAM and the ring output, and tracks downstream credits.
// Upstream credits leave on ringInCredit, downstream ones arrive on
// ringOutCredit.

`timescale 1ns/1ps

module ringRamNode import ringPkg::*; (
  input  logic       CLK,
  input  logic       rstN,
  input  ringPacketT ringIn,
  input  logic       ringInValid,
  output logic       ringInCredit,
  output ringPacketT ringOut,
  output logic       ringOutValid,
  input  logic       ringOutCredit
);

  ringPacketT headPacket;
  logic       notEmpty;
  logic       pop;
  logic       ramEnable;
  logic       ramWrite;
  ramAddrT    ramAddr;
  byteMaskT   ramMask;
  wordT       ramWrData;
  wordT       ramRdData;
  logic       creditAvailable;

  // Every valid flit from upstream is stored, there is no ready
  packetQueue i_packetQueue (
    .CLK          (CLK),
    .rstN         (rstN),
    .push         (ringInValid),
    .pushPacket   (ringIn),
    .pop          (pop),
    .headPacket   (headPacket),
    .notEmpty     (notEmpty),
    .creditReturn (ringInCredit)
  );

  // Each flit sent downstream spends one credit
  creditCounter i_creditCounter (
    .CLK       (CLK),
    .rstN      (rstN),
    .consume   (ringOutValid),
    .restore   (ringOutCredit),
    .available (creditAvailable)
  );

  sharedRam i_sharedRam (
    .CLK    (CLK),
    .enable (ramEnable),
    .write  (ramWrite),
    .addr   (ramAddr),
    .mask   (ramMask),
    .wrData (ramWrData),
    .rdData (ramRdData)
  );

  ringBridgeCtrl i_ringBridgeCtrl (
    .CLK             (CLK),
    .rstN            (rstN),
    .notEmpty        (notEmpty),
    .headPacket      (headPacket),
    .pop             (pop),
    .ramEnable       (ramEnable),
    .ramWrite        (ramWrite),
    .ramAddr         (ramAddr),
    .ramMask         (ramMask),
    .ramWrData       (ramWrData),
    .ramRdData       (ramRdData),
    .creditAvailable (creditAvailable),
    .ringOut         (ringOut),
    .ringOutValid    (ringOutValid)
  );

endmodule

//--- source/ringBridgeCtrl.sv
// Controller between the input queue, the RAM and the downstream ring.
// Takes one packet at a time from the queue, performs the RAM access when
// the packet is a request inside the node's window, and then sends either
// the response or the untouched packet once a downstream credit exists.

`timescale 1ns/1ps

module ringBridgeCtrl import ringPkg::*; (
  input  logic       CLK,
  input  logic       rstN,
  input  logic       notEmpty,
  input  ringPacketT headPacket,
  output logic       pop,
  output logic       ramEnable,
  output logic       ramWrite,
  output ramAddrT    ramAddr,
  output byteMaskT   ramMask,
  output wordT       ramWrData,
  input  wordT       ramRdData,
  input  logic       creditAvailable,
  output ringPacketT ringOut,
  output logic       ringOutValid
);

  bridgeStateT state;
  ringPacketT  heldPacket;
  logic        isRequest;
  logic        accessHit;
  logic        hitFlag;

  // Only read and write requests can hit, responses always pass through
  assign isRequest = (heldPacket.kind == KIND_READ) || (heldPacket.kind == KIND_WRITE);
  assign accessHit = isRequest && ((heldPacket.addr & WINDOW_MASK) == WINDOW_BASE);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state   <= IDLE;
      hitFlag <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (notEmpty) begin
            state <= ACCESS;
          end
        end
        ACCESS: begin
          // The hit decision is made once here and kept for SEND
          hitFlag <= accessHit;
          state   <= SEND;
        end
        SEND: begin
          if (creditAvailable) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Holding register for the packet in flight, payload only
  always_ff @(posedge CLK) begin
    if (pop) begin
      heldPacket <= headPacket;
    end
  end

  assign pop = (state == IDLE) && notEmpty;

  // The RAM sees one access per hit, in the single ACCESS cycle
  assign ramEnable = (state == ACCESS) && accessHit;
  assign ramWrite  = (heldPacket.kind == KIND_WRITE);
  assign ramAddr   = heldPacket.addr[RAM_ADDR_W+1:2];
  assign ramMask   = heldPacket.mask;
  assign ramWrData = heldPacket.data;

  // A hit becomes a response carrying the read word, or zero for a write
  always_comb begin
    ringOut = heldPacket;
    if (hitFlag) begin
      ringOut.kind = KIND_RESP;
      ringOut.data = (heldPacket.kind == KIND_READ) ? ramRdData : '0;
    end
  end

  assign ringOutValid = (state == SEND) && creditAvailable;

  // Unknown bits in a sent packet point at an unwritten RAM word or an
  // empty queue slot reaching the ring
  assert property (@(posedge CLK) disable iff (!rstN)
    ringOutValid |-> !$isunknown(ringOut));

endmodule

//--- source/sharedRam.sv
// Word-organised RAM behind the ring node.
// Writes merge only the bytes selected by the mask into the stored word.
// Reads return the addressed word on the edge after the request and
// hold it until the next read.

`timescale 1ns/1ps

module sharedRam import ringPkg::*; (
  input  logic     CLK,
  input  logic     enable,
  input  logic     write,
  input  ramAddrT  addr,
  input  byteMaskT mask,
  input  wordT     wrData,
  output wordT     rdData
);

  wordT memory [RAM_WORDS];
  wordT bitMask;

  // Spread each mask bit over the eight bits of its byte lane
  assign bitMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};

  always_ff @(posedge CLK) begin
    if (enable && write) begin
      memory[addr] <= (memory[addr] & ~bitMask) | (wrData & bitMask);
    end
  end

  // Read data only changes on a read, so it stays valid while the
  // controller waits for a downstream credit
  always_ff @(posedge CLK) begin
    if (enable && !write) begin
      rdData <= memory[addr];
    end
  end

endmodule

//--- source/creditCounter.sv
// Downstream credit counter.
// Starts with the credits granted by the downstream hop, spends one per
// packet sent and gains one per credit pulse returned.

`timescale 1ns/1ps

module creditCounter import ringPkg::*; (
  input  logic CLK,
  input  logic rstN,
  input  logic consume,
  input  logic restore,
  output logic available
);

  logic [CREDIT_CNT_W-1:0] count;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      count <= CREDIT_CNT_W'(OUT_CREDITS);
    end else begin
      // A send and a returned credit in the same cycle cancel out
      case ({consume, restore})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sending is allowed while any credit is left
  assign available = (count != '0);

  // Consume is driven by ringOutValid, so this checks the controller
  // honours the credit flag over time
  assert property (@(posedge CLK) disable iff (!rstN)
    consume |-> count != '0);

  // More credits than granted means the downstream hop returned extras
  assert property (@(posedge CLK) disable iff (!rstN)
    count <= CREDIT_CNT_W'(OUT_CREDITS));

endmodule

//--- source/packetQueue.sv
// Input queue of the ring node.
// Stores every packet the upstream hop sends and presents the oldest one
// at its head. Each pop frees a slot, which goes back upstream as a
// one-cycle credit pulse on the following clock.

`timescale 1ns/1ps

module packetQueue import ringPkg::*; (
  input  logic       CLK,
  input  logic       rstN,
  input  logic       push,
  input  ringPacketT pushPacket,
  input  logic       pop,
  output ringPacketT headPacket,
  output logic       notEmpty,
  output logic       creditReturn
);

  ringPacketT              entries [IN_QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0]  wrPtr;
  logic [QUEUE_PTR_W-1:0]  rdPtr;
  logic [QUEUE_CNT_W-1:0]  count;

  // Packet storage, written at the write pointer on every push
  always_ff @(posedge CLK) begin
    if (push) begin
      entries[wrPtr] <= pushPacket;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == QUEUE_PTR_W'(IN_QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == QUEUE_PTR_W'(IN_QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Push and pop in one cycle leave the occupancy as it is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // A freed slot is handed back upstream one cycle after the pop
      creditReturn <= pop;
    end
  end

  assign headPacket = entries[rdPtr];
  assign notEmpty   = (count != '0);

  // The upstream hop may only send while holding a credit, so a full
  // queue means a credit was spent twice somewhere on the ring
  assert property (@(posedge CLK) disable iff (!rstN)
    push |-> count != QUEUE_CNT_W'(IN_QUEUE_DEPTH));

  assert property (@(posedge CLK) disable iff (!rstN)
    pop |-> notEmpty);

endmodule

//--- source/ringPkg.sv
// Shared definitions for the ring memory node.
// Holds the packet layout, packet kind codes, vector types and the
// sizing localparams used by the node and by its testbench.
// Modules pull these in with a wildcard import in their header.

package ringPkg;

  // Memory and queue sizing
  localparam int RAM_WORDS      = 1024;
  localparam int IN_QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS    = 2;

  // Derived widths for pointers and counters
  localparam int RAM_ADDR_W   = $clog2(RAM_WORDS);
  localparam int QUEUE_PTR_W  = $clog2(IN_QUEUE_DEPTH);
  localparam int QUEUE_CNT_W  = $clog2(IN_QUEUE_DEPTH + 1);
  localparam int CREDIT_CNT_W = $clog2(OUT_CREDITS + 1);

  // Address window that this node answers
  localparam logic [31:0] WINDOW_BASE = 32'h0001_0000;
  localparam logic [31:0] WINDOW_MASK = 32'hFFFF_0000;

  typedef logic [31:0]           wordT;
  typedef logic [31:0]           addrT;
  typedef logic [3:0]            byteMaskT;
  typedef logic [3:0]            nodeIdT;
  typedef logic [1:0]            kindT;
  typedef logic [RAM_ADDR_W-1:0] ramAddrT;

  // Packet kinds carried in the kind field
  localparam kindT KIND_READ  = 2'd1;
  localparam kindT KIND_WRITE = 2'd2;
  localparam kindT KIND_RESP  = 2'd3;

  // One ring packet, sent as a single flit
  typedef struct packed {
    kindT     kind;
    nodeIdT   srcId;
    addrT     addr;
    byteMaskT mask;
    wordT     data;
  } ringPacketT;

  // Controller states, kept here so the testbench can print them
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    SEND
  } bridgeStateT;

endpackage
